// File: verilog/neuro_pkg.sv
package neuro_pkg;

	// ------------------------------
	// neuron state array select
	// ------------------------------
	typedef enum logic [1:0] {
		SEL_BIAS = 2'b00,
		SEL_POT  = 2'b01,
		SEL_TH   = 2'b10
	} stat_sel_e;

	// host write target whose state codes match stat_sel_e
	typedef enum logic [1:0] {
		CFG_BIAS   = 2'b00,
		CFG_POT    = 2'b01,
		CFG_TH     = 2'b10,
		CFG_WEIGHT = 2'b11
	} cfg_op_e;

	// state read sequencer
	typedef enum logic [2:0] {
		IDLE,
		RD_BIAS,
		RD_POT,
		RD_TH,
		HOLD
	} fetch_state_e;

	// potential after a spike
	localparam logic signed [15:0] V_RESET = 16'sd0;

endpackage

// File: verilog/stat_rd_if.sv
interface stat_rd_if #(
	parameter int NURN_W = 8,
	parameter int DSIZE  = 16
);

	// request side
	logic                  en;
	neuro_pkg::stat_sel_e  sel;
	logic [NURN_W-1:0]     addr;

	// registered return held while en is low
	logic [DSIZE-1:0]      data;

	modport req (
		output en, sel, addr,
		input  data
	);

	modport mem (
		input  en, sel, addr,
		output data
	);

endinterface

// File: verilog/status_mem.sv
module status_mem #(
	parameter int NUM_NURNS = 256,
	parameter int NUM_AXONS = 256,
	parameter int DSIZE     = 16
) (
	input  logic                            clk_i,
	input  logic                            rst_n_i,

	// neuron state read port
	stat_rd_if.mem                          st_rd,

	// neuron state write port
	input  logic                            st_wr_en_i,
	input  neuro_pkg::stat_sel_e            st_wr_sel_i,
	input  logic [$clog2(NUM_NURNS)-1:0]    st_wr_addr_i,
	input  logic [DSIZE-1:0]                st_wr_data_i,

	// weight read port
	input  logic                            wt_rd_en_i,
	input  logic [$clog2(NUM_NURNS)+$clog2(NUM_AXONS)-1:0] wt_rd_addr_i,
	output logic [DSIZE-1:0]                wt_rd_data_o,

	// weight write port
	input  logic                            wt_wr_en_i,
	input  logic [$clog2(NUM_NURNS)+$clog2(NUM_AXONS)-1:0] wt_wr_addr_i,
	input  logic [DSIZE-1:0]                wt_wr_data_i
);

	localparam int NURN_W = $clog2(NUM_NURNS);
	localparam int AXON_W = $clog2(NUM_AXONS);
	localparam int WT_W   = NURN_W + AXON_W;

	// ------------------------------
	// storage
	// ------------------------------
	logic [DSIZE-1:0] bias_mem [NUM_NURNS];
	logic [DSIZE-1:0] pot_mem  [NUM_NURNS];
	logic [DSIZE-1:0] th_mem   [NUM_NURNS];

	// one row of NUM_AXONS weights per neuron
	logic [DSIZE-1:0] wt_mem   [NUM_NURNS*NUM_AXONS];

	// ------------------------------
	// registered reads
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			st_rd.data <= '0;
		end else if (st_rd.en) begin
			case (st_rd.sel)
				neuro_pkg::SEL_BIAS: begin
					st_rd.data <= bias_mem[st_rd.addr];
				end
				neuro_pkg::SEL_POT: begin
					st_rd.data <= pot_mem[st_rd.addr];
				end
				neuro_pkg::SEL_TH: begin
					st_rd.data <= th_mem[st_rd.addr];
				end
				default: begin
					// spare code keeps the last word
					st_rd.data <= st_rd.data;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wt_rd_data_o <= '0;
		end else if (wt_rd_en_i) begin
			wt_rd_data_o <= wt_mem[wt_rd_addr_i];
		end
	end

	// ------------------------------
	// writes
	// ------------------------------
	always_ff @(posedge clk_i) begin
		if (st_wr_en_i) begin
			case (st_wr_sel_i)
				neuro_pkg::SEL_BIAS: begin
					bias_mem[st_wr_addr_i] <= st_wr_data_i;
				end
				neuro_pkg::SEL_POT: begin
					pot_mem[st_wr_addr_i] <= st_wr_data_i;
				end
				neuro_pkg::SEL_TH: begin
					th_mem[st_wr_addr_i] <= st_wr_data_i;
				end
				default: begin
				end
			endcase
		end
	end

	// weights are only changed by the host
	always_ff @(posedge clk_i) begin
		if (wt_wr_en_i) begin
			wt_mem[WT_W'(wt_wr_addr_i)] <= wt_wr_data_i;
		end
	end

endmodule

// File: verilog/weight_fifo.sv
module weight_fifo #(
	parameter int FIFO_DEPTH = 4,
	parameter int DSIZE      = 16
) (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             push_i,
	input  logic [DSIZE-1:0] push_data_i,
	input  logic             pop_i,
	output logic [DSIZE-1:0] pop_data_o,
	output logic             empty_o,
	output logic             full_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [DSIZE-1:0] buf_mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign empty_o = (count == '0);
	assign full_o  = (count == CNT_W'(FIFO_DEPTH));

	// overflow pushes and underflow pops are dropped
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	// head word shows without a pop
	assign pop_data_o = buf_mem[rd_ptr];

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			buf_mem[wr_ptr] <= push_data_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verilog/state_fetch.sv
module state_fetch #(
	parameter int NUM_NURNS = 256,
	parameter int DSIZE     = 16
) (
	input  logic                         clk_i,
	input  logic                         rst_n_i,
	input  logic                         evt_i,
	input  logic [$clog2(NUM_NURNS)-1:0] evt_nurn_i,
	stat_rd_if.req                       st_rd,
	output logic                         state_vld_o,
	output logic [$clog2(NUM_NURNS)-1:0] nurn_o,
	output logic [DSIZE-1:0]             bias_o,
	output logic [DSIZE-1:0]             pot_o,
	output logic [DSIZE-1:0]             th_o
);

	neuro_pkg::fetch_state_e state_q;
	neuro_pkg::fetch_state_e state_d;

	// ------------------------------
	// sequencer
	// ------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			neuro_pkg::IDLE:    if (evt_i) state_d = neuro_pkg::RD_BIAS;
			neuro_pkg::RD_BIAS: state_d = neuro_pkg::RD_POT;
			neuro_pkg::RD_POT:  state_d = neuro_pkg::RD_TH;
			neuro_pkg::RD_TH:   state_d = neuro_pkg::HOLD;
			default:            state_d = neuro_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= neuro_pkg::IDLE;
			state_vld_o <= 1'b0;
		end else begin
			state_q     <= state_d;
			state_vld_o <= (state_q == neuro_pkg::HOLD);
		end
	end

	// one read per state that the memory takes on the next edge
	assign st_rd.en   = (state_q == neuro_pkg::RD_BIAS) || (state_q == neuro_pkg::RD_POT) ||
	                    (state_q == neuro_pkg::RD_TH);
	assign st_rd.sel  = (state_q == neuro_pkg::RD_POT) ? neuro_pkg::SEL_POT :
	                    (state_q == neuro_pkg::RD_TH)  ? neuro_pkg::SEL_TH  :
	                                                     neuro_pkg::SEL_BIAS;
	assign st_rd.addr = nurn_o;

	// ------------------------------
	// capture
	// ------------------------------
	// each word lands while the next read is out
	always_ff @(posedge clk_i) begin
		if (state_q == neuro_pkg::IDLE && evt_i) begin
			nurn_o <= evt_nurn_i;
		end
		if (state_q == neuro_pkg::RD_POT) begin
			bias_o <= st_rd.data;
		end
		if (state_q == neuro_pkg::RD_TH) begin
			pot_o <= st_rd.data;
		end
		if (state_q == neuro_pkg::HOLD) begin
			th_o <= st_rd.data;
		end
	end

endmodule

// File: verilog/synapse_fetch.sv
module synapse_fetch #(
	parameter int NUM_NURNS = 256,
	parameter int NUM_AXONS = 256,
	parameter int DSIZE     = 16
) (
	input  logic                                           clk_i,
	input  logic                                           rst_n_i,
	input  logic                                           evt_i,
	input  logic [$clog2(NUM_NURNS)-1:0]                   evt_nurn_i,
	input  logic [$clog2(NUM_AXONS)-1:0]                   evt_axon_i,
	output logic                                           wt_rd_en_o,
	output logic [$clog2(NUM_NURNS)+$clog2(NUM_AXONS)-1:0] wt_rd_addr_o,
	input  logic [DSIZE-1:0]                               wt_rd_data_i,
	output logic                                           push_o,
	output logic [DSIZE-1:0]                               push_data_o
);

	// high while the memory output holds a fresh weight
	logic rd_vld_q;

	// ------------------------------
	// read issue and push timing
	// ------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wt_rd_en_o <= 1'b0;
			rd_vld_q   <= 1'b0;
			push_o     <= 1'b0;
		end else begin
			wt_rd_en_o <= evt_i;
			rd_vld_q   <= wt_rd_en_o;
			push_o     <= rd_vld_q;
		end
	end

	// row is the neuron, column the axon
	always_ff @(posedge clk_i) begin
		if (evt_i) begin
			wt_rd_addr_o <= {evt_nurn_i, evt_axon_i};
		end
		if (rd_vld_q) begin
			push_data_o <= wt_rd_data_i;
		end
	end

endmodule

// File: verilog/soma_update.sv
module soma_update #(
	parameter int NUM_NURNS = 256,
	parameter int DSIZE     = 16
) (
	input  logic                          clk_i,
	input  logic                          rst_n_i,
	input  logic                          state_vld_i,
	input  logic [$clog2(NUM_NURNS)-1:0]  nurn_i,
	input  logic signed [DSIZE-1:0]       bias_i,
	input  logic signed [DSIZE-1:0]       pot_i,
	input  logic signed [DSIZE-1:0]       th_i,
	output logic                          pop_o,
	input  logic signed [DSIZE-1:0]       pop_data_i,
	input  logic                          empty_i,
	input  logic                          host_we_i,
	input  neuro_pkg::cfg_op_e            host_sel_i,
	input  logic [$clog2(NUM_NURNS)-1:0]  host_addr_i,
	input  logic [DSIZE-1:0]              host_data_i,
	output logic                          st_wr_en_o,
	output neuro_pkg::stat_sel_e          st_wr_sel_o,
	output logic [$clog2(NUM_NURNS)-1:0]  st_wr_addr_o,
	output logic [DSIZE-1:0]              st_wr_data_o,
	output logic                          done_o,
	output logic [$clog2(NUM_NURNS)-1:0]  done_nurn_o,
	output logic                          fire_o,
	output logic signed [DSIZE-1:0]       pot_o
);

	localparam logic signed [DSIZE+1:0] POT_MAX = (DSIZE+2)'({1'b0, {(DSIZE-1){1'b1}}});
	localparam logic signed [DSIZE+1:0] POT_MIN = -POT_MAX - 1;

	logic signed [DSIZE+1:0] sum_wide;
	logic signed [DSIZE-1:0] sum_sat;
	logic                    fire;

	// ------------------------------
	// integrate and fire
	// ------------------------------
	assign pop_o = state_vld_i && !empty_i;

	// two guard bits cover three operands
	assign sum_wide = (DSIZE+2)'(pot_i) + (DSIZE+2)'(bias_i) + (DSIZE+2)'(pop_data_i);

	always_comb begin
		if (sum_wide > POT_MAX) begin
			sum_sat = POT_MAX[DSIZE-1:0];
		end else if (sum_wide < POT_MIN) begin
			sum_sat = POT_MIN[DSIZE-1:0];
		end else begin
			sum_sat = sum_wide[DSIZE-1:0];
		end
	end

	assign fire = (sum_sat >= th_i);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			done_o <= 1'b0;
			fire_o <= 1'b0;
		end else begin
			done_o <= pop_o;
			fire_o <= pop_o && fire;
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			done_nurn_o <= nurn_i;
			pot_o       <= fire ? DSIZE'(neuro_pkg::V_RESET) : sum_sat;
		end
	end

	// ------------------------------
	// write-back wins over host writes
	// ------------------------------
	assign st_wr_en_o   = done_o || host_we_i;
	assign st_wr_sel_o  = done_o ? neuro_pkg::SEL_POT : neuro_pkg::stat_sel_e'(host_sel_i);
	assign st_wr_addr_o = done_o ? done_nurn_o : host_addr_i;
	assign st_wr_data_o = done_o ? pot_o : host_data_i;

endmodule

// File: verilog/neuro_core.sv
module neuro_core #(
	parameter int NUM_NURNS  = 256,
	parameter int NUM_AXONS  = 256,
	parameter int DSIZE      = 16,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                           clk_i,
	input  logic                                           rst_n_i,
	input  logic                                           evt_i,
	input  logic [$clog2(NUM_NURNS)-1:0]                   evt_nurn_i,
	input  logic [$clog2(NUM_AXONS)-1:0]                   evt_axon_i,
	input  logic                                           cfg_we_i,
	input  neuro_pkg::cfg_op_e                             cfg_op_i,
	input  logic [$clog2(NUM_NURNS)+$clog2(NUM_AXONS)-1:0] cfg_addr_i,
	input  logic [DSIZE-1:0]                               cfg_data_i,
	output logic                                           done_o,
	output logic [$clog2(NUM_NURNS)-1:0]                   done_nurn_o,
	output logic                                           fire_o,
	output logic signed [DSIZE-1:0]                        pot_o
);

	localparam int NURN_W = $clog2(NUM_NURNS);
	localparam int AXON_W = $clog2(NUM_AXONS);

	logic                      wt_rd_en;
	logic [NURN_W+AXON_W-1:0]  wt_rd_addr;
	logic [DSIZE-1:0]          wt_rd_data;
	logic                      push;
	logic [DSIZE-1:0]          push_data;
	logic                      pop;
	logic [DSIZE-1:0]          pop_data;
	logic                      fifo_empty;
	logic                      state_vld;
	logic [NURN_W-1:0]         vld_nurn;
	logic [DSIZE-1:0]          vld_bias;
	logic [DSIZE-1:0]          vld_pot;
	logic [DSIZE-1:0]          vld_th;
	logic                      st_wr_en;
	neuro_pkg::stat_sel_e      st_wr_sel;
	logic [NURN_W-1:0]         st_wr_addr;
	logic [DSIZE-1:0]          st_wr_data;
	logic                      cfg_wt_we;
	logic                      cfg_st_we;

	// weights go straight to memory, state through the soma arbiter
	assign cfg_wt_we = cfg_we_i && (cfg_op_i == neuro_pkg::CFG_WEIGHT);
	assign cfg_st_we = cfg_we_i && (cfg_op_i != neuro_pkg::CFG_WEIGHT);

	stat_rd_if #(.NURN_W(NURN_W), .DSIZE(DSIZE)) st_rd ();

	status_mem #(.NUM_NURNS(NUM_NURNS), .NUM_AXONS(NUM_AXONS), .DSIZE(DSIZE)) i_status_mem (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .st_rd(st_rd),
		.st_wr_en_i(st_wr_en), .st_wr_sel_i(st_wr_sel),
		.st_wr_addr_i(st_wr_addr), .st_wr_data_i(st_wr_data),
		.wt_rd_en_i(wt_rd_en), .wt_rd_addr_i(wt_rd_addr), .wt_rd_data_o(wt_rd_data),
		.wt_wr_en_i(cfg_wt_we), .wt_wr_addr_i(cfg_addr_i), .wt_wr_data_i(cfg_data_i)
	);

	state_fetch #(.NUM_NURNS(NUM_NURNS), .DSIZE(DSIZE)) i_state_fetch (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .evt_i(evt_i), .evt_nurn_i(evt_nurn_i),
		.st_rd(st_rd), .state_vld_o(state_vld), .nurn_o(vld_nurn),
		.bias_o(vld_bias), .pot_o(vld_pot), .th_o(vld_th)
	);

	synapse_fetch #(.NUM_NURNS(NUM_NURNS), .NUM_AXONS(NUM_AXONS), .DSIZE(DSIZE)) i_synapse_fetch (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .evt_i(evt_i),
		.evt_nurn_i(evt_nurn_i), .evt_axon_i(evt_axon_i),
		.wt_rd_en_o(wt_rd_en), .wt_rd_addr_o(wt_rd_addr), .wt_rd_data_i(wt_rd_data),
		.push_o(push), .push_data_o(push_data)
	);

	// full is never reached at the allowed event rate
	weight_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .DSIZE(DSIZE)) i_weight_fifo (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .push_i(push), .push_data_i(push_data),
		.pop_i(pop), .pop_data_o(pop_data), .empty_o(fifo_empty), .full_o()
	);

	soma_update #(.NUM_NURNS(NUM_NURNS), .DSIZE(DSIZE)) i_soma_update (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .state_vld_i(state_vld), .nurn_i(vld_nurn),
		.bias_i(vld_bias), .pot_i(vld_pot), .th_i(vld_th),
		.pop_o(pop), .pop_data_i(pop_data), .empty_i(fifo_empty),
		.host_we_i(cfg_st_we), .host_sel_i(cfg_op_i),
		.host_addr_i(cfg_addr_i[NURN_W+AXON_W-1:AXON_W]), .host_data_i(cfg_data_i),
		.st_wr_en_o(st_wr_en), .st_wr_sel_o(st_wr_sel),
		.st_wr_addr_o(st_wr_addr), .st_wr_data_o(st_wr_data),
		.done_o(done_o), .done_nurn_o(done_nurn_o), .fire_o(fire_o), .pot_o(pot_o)
	);

endmodule

// File: testbench/tb_neuro_core.sv
module tb_neuro_core;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NURNS      = 16;
	localparam int AXONS      = 8;
	localparam int DSIZE      = 16;
	localparam int NURN_W     = $clog2(NURNS);
	localparam int AXON_W     = $clog2(AXONS);
	localparam int CLK_PERIOD = 4;
	localparam int N_RAND     = 12;
	localparam int N_REWRITE  = 4;
	localparam int N_EVENTS   = N_RAND + 3 + AXONS + 3 + N_REWRITE;
	// reset, loading and slack on top of 8 cycles per event
	localparam int TIMEOUT_CYCLES = 8 + NURNS * (3 + AXONS) + N_EVENTS * 8 + 200;

	typedef struct packed {
		logic                    fire;
		logic [NURN_W-1:0]       nurn;
		logic signed [DSIZE-1:0] pot;
	} result_t;

	logic                     clk_i;
	logic                     rst_n_i;
	logic                     evt_i;
	logic [NURN_W-1:0]        evt_nurn_i;
	logic [AXON_W-1:0]        evt_axon_i;
	logic                     cfg_we_i;
	neuro_pkg::cfg_op_e       cfg_op_i;
	logic [NURN_W+AXON_W-1:0] cfg_addr_i;
	logic [DSIZE-1:0]         cfg_data_i;
	logic                     done_o;
	logic [NURN_W-1:0]        done_nurn_o;
	logic                     fire_o;
	logic signed [DSIZE-1:0]  pot_o;

	// shadow copy of everything the host loaded
	logic signed [DSIZE-1:0] sh_bias [NURNS];
	logic signed [DSIZE-1:0] sh_pot  [NURNS];
	logic signed [DSIZE-1:0] sh_th   [NURNS];
	logic signed [DSIZE-1:0] sh_wt   [NURNS*AXONS];

	result_t    exp_res;
	result_t    res_dly [6];
	logic [5:0] evt_dly;
	logic       evt_seen;
	int         reset_errs;
	int         latency_errs;
	int         value_errs;

	neuro_core #(.NUM_NURNS(NURNS), .NUM_AXONS(AXONS), .DSIZE(DSIZE)) i_neuro_core (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .evt_i(evt_i),
		.evt_nurn_i(evt_nurn_i), .evt_axon_i(evt_axon_i),
		.cfg_we_i(cfg_we_i), .cfg_op_i(cfg_op_i),
		.cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i),
		.done_o(done_o), .done_nurn_o(done_nurn_o), .fire_o(fire_o), .pot_o(pot_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// ------------------------------
	// expected results delayed to line up with done_o
	// ------------------------------
	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			evt_dly <= '0;
		end else begin
			evt_dly    <= {evt_dly[4:0], evt_i};
			res_dly[0] <= exp_res;
			for (int i = 5; i > 0; i--) begin
				res_dly[i] <= res_dly[i-1];
			end
		end
	end

	a_reset_quiet: assert property (@(posedge clk_i) !evt_seen |-> (!done_o && !fire_o))
		else begin
			reset_errs++;
			$display("Mismatch at %0t: done_o or fire_o high before the first event", $time);
		end

	a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_o == evt_dly[5])
		else begin
			latency_errs++;
			$display("Mismatch at %0t: done_o %0b, expected %0b", $time,
				$sampled(done_o), $sampled(evt_dly[5]));
		end

	a_fire_gated: assert property (@(posedge clk_i) disable iff (!rst_n_i) !done_o |-> !fire_o)
		else begin
			value_errs++;
			$display("Mismatch at %0t: fire_o high without done_o", $time);
		end

	a_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |-> ({fire_o, done_nurn_o, pot_o} == res_dly[5]))
		else begin
			value_errs++;
			$display("Mismatch at %0t: fire %0b nurn %0d pot %0d, expected %0b %0d %0d",
				$time, $sampled(fire_o), $sampled(done_nurn_o), $sampled(pot_o),
				$sampled(res_dly[5].fire), $sampled(res_dly[5].nurn), $sampled(res_dly[5].pot));
		end

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic tick();
		@(posedge clk_i);
		#0.5;
	endtask

	task automatic load_word(input neuro_pkg::cfg_op_e op, input int n, input int a,
		input int data);
		cfg_we_i   = 1'b1;
		cfg_op_i   = op;
		cfg_addr_i = {NURN_W'(n), AXON_W'(a)};
		cfg_data_i = DSIZE'(data);
		case (op)
			neuro_pkg::CFG_BIAS: sh_bias[NURN_W'(n)] = DSIZE'(data);
			neuro_pkg::CFG_POT:  sh_pot[NURN_W'(n)] = DSIZE'(data);
			neuro_pkg::CFG_TH:   sh_th[NURN_W'(n)] = DSIZE'(data);
			default:             sh_wt[{NURN_W'(n), AXON_W'(a)}] = DSIZE'(data);
		endcase
		tick();
		cfg_we_i = 1'b0;
	endtask

	// integrate, clamp to 16 bits signed, fire at or above threshold
	task automatic predict_soma(input int n, input int a);
		int sum;
		sum = int'(sh_pot[NURN_W'(n)]) + int'(sh_bias[NURN_W'(n)]) +
			int'(sh_wt[{NURN_W'(n), AXON_W'(a)}]);
		if (sum > 32767) begin
			sum = 32767;
		end else if (sum < -32768) begin
			sum = -32768;
		end
		exp_res.fire = (sum >= int'(sh_th[NURN_W'(n)]));
		exp_res.nurn = NURN_W'(n);
		exp_res.pot  = exp_res.fire ? neuro_pkg::V_RESET : DSIZE'(sum);
		sh_pot[NURN_W'(n)] = exp_res.pot;
	endtask

	// one event followed by the minimum spacing of 6 cycles
	task automatic send_event(input int n, input int a);
		predict_soma(n, a);
		evt_i      = 1'b1;
		evt_nurn_i = NURN_W'(n);
		evt_axon_i = AXON_W'(a);
		evt_seen   = 1'b1;
		tick();
		evt_i = 1'b0;
		repeat (5) tick();
	endtask

	// wait out the pending done before host writes
	task automatic settle();
		do begin
			@(negedge clk_i);
		end while (!done_o);
		tick();
	endtask

	initial begin
		void'($urandom(32'hb3b1_7843));
		clk_i        = 1'b0;
		rst_n_i      = 1'b0;
		evt_i        = 1'b0;
		evt_nurn_i   = '0;
		evt_axon_i   = '0;
		cfg_we_i     = 1'b0;
		cfg_op_i     = neuro_pkg::CFG_BIAS;
		cfg_addr_i   = '0;
		cfg_data_i   = '0;
		exp_res      = '0;
		evt_seen     = 1'b0;
		reset_errs   = 0;
		latency_errs = 0;
		value_errs   = 0;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int n;
		int a;
		#0.5;
		repeat (8) tick();
		rst_n_i = 1'b1;
		tick();
		// small random state with thresholds out of reach
		for (int i = 0; i < NURNS; i++) begin
			load_word(neuro_pkg::CFG_BIAS, i, 0, int'($urandom_range(15)) - 8);
			load_word(neuro_pkg::CFG_POT, i, 0, int'($urandom_range(63)) - 32);
			load_word(neuro_pkg::CFG_TH, i, 0, 1000);
			for (int j = 0; j < AXONS; j++) begin
				load_word(neuro_pkg::CFG_WEIGHT, i, j, int'($urandom_range(31)) - 16);
			end
		end
		for (int i = 0; i < N_RAND; i++) begin
			n = int'($urandom_range(NURNS - 1));
			a = int'($urandom_range(AXONS - 1));
			send_event(n, a);
		end
		// fire, integrate from reset, fire again
		settle();
		load_word(neuro_pkg::CFG_TH, 3, 0, 20);
		load_word(neuro_pkg::CFG_POT, 3, 0, 10);
		load_word(neuro_pkg::CFG_BIAS, 3, 0, 5);
		load_word(neuro_pkg::CFG_WEIGHT, 3, 0, 10);
		repeat (3) send_event(3, 0);
		// one distinct weight per axon
		settle();
		load_word(neuro_pkg::CFG_TH, 5, 0, 32767);
		for (int j = 0; j < AXONS; j++) begin
			load_word(neuro_pkg::CFG_WEIGHT, 5, j, (j + 1) * 37);
		end
		for (int j = 0; j < AXONS; j++) begin
			send_event(5, j);
		end
		// positive clamp fires and negative clamp sticks at the limit
		settle();
		load_word(neuro_pkg::CFG_TH, 7, 0, 32767);
		load_word(neuro_pkg::CFG_POT, 7, 0, 30000);
		load_word(neuro_pkg::CFG_BIAS, 7, 0, 2000);
		load_word(neuro_pkg::CFG_WEIGHT, 7, 1, 2000);
		load_word(neuro_pkg::CFG_WEIGHT, 7, 2, -2000);
		send_event(7, 1);
		settle();
		load_word(neuro_pkg::CFG_POT, 7, 0, -30000);
		load_word(neuro_pkg::CFG_BIAS, 7, 0, -2000);
		repeat (2) send_event(7, 2);
		for (int i = 0; i < N_REWRITE; i++) begin
			n = int'($urandom_range(NURNS - 1));
			a = int'($urandom_range(AXONS - 1));
			settle();
			load_word(neuro_pkg::CFG_POT, n, 0, int'($urandom_range(2000)) - 1000);
			send_event(n, a);
		end
		settle();
		repeat (2) tick();
		$display("errors: reset %0d, latency %0d, value %0d",
			reset_errs, latency_errs, value_errs);
		if (reset_errs + latency_errs + value_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
verilog/neuro_pkg.sv
verilog/stat_rd_if.sv
verilog/status_mem.sv
verilog/weight_fifo.sv
verilog/state_fetch.sv
verilog/synapse_fetch.sv
verilog/soma_update.sv
verilog/neuro_core.sv
testbench/tb_neuro_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_neuro_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
